//--- src/dcache_pkg.sv
/* dcache tag store shared definitions
   address fields, tag entry and lookup response types */
`default_nettype none

package dcache_pkg;

    localparam int TAG_W    = 21;                    // addr[31:11]
    localparam int INDEX_W  = 8;                     // 256 sets
    localparam int OFFSET_W = 3;                     // byte in line
    localparam int THREAD_W = 2;                     // owner thread id

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [THREAD_W-1:0] thread_t;
    typedef logic                way_t;              // way 0 or way 1

    typedef struct packed {
        tag_t                tag;
        index_t              index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;                                  // 32-bit request address

    typedef struct packed {
        logic    valid;
        logic    dirty;
        thread_t thread;
        tag_t    tag;
    } way_entry_t;                                   // one way of one set

    typedef struct packed {
        logic    hit;
        way_t    hit_way;
        way_t    victim_way;
        logic    victim_dirty;
        tag_t    victim_tag;
        thread_t victim_thread;
    } tag_resp_t;

endpackage

`default_nettype wire

//--- src/tag_sram.sv
/* synchronous single-port RAM
   read-enabled registered output, write on clk */
`timescale 1ns/1ps
`default_nettype none

module tag_sram #(
    parameter int WIDTH = 21,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] address,
    input  logic                     wren,
    input  logic                     rden,
    input  logic [WIDTH-1:0]         data,
    output logic [WIDTH-1:0]         q
);

    logic [WIDTH-1:0] mem [DEPTH];                   // storage array

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[address] <= data;
        end
    end

    // read-first, q holds when rden is low
    always_ff @(posedge clk) begin
        if (rden) begin
            q <= mem[address];
        end
    end

endmodule

`default_nettype wire

//--- src/dtag_ram.sv
/* dcache tag RAM, two ways of tag, thread and dirty SRAM
   plus valid and LRU flops per set and write completion */
`timescale 1ns/1ps
`default_nettype none

module dtag_ram import dcache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  index_t     index,
    input  logic       way0_we,
    input  logic       way1_we,
    input  logic       tag_we,                       // fill, writes tag/thread/valid
    input  logic       dirty_set,                    // store sets dirty, fill clears it
    input  logic       read_en,
    input  tag_t       tag_wd,
    input  thread_t    thread_wd,
    output way_entry_t way0,
    output way_entry_t way1,
    output way_t       lru,
    output logic       w_complete
);

    localparam int DEPTH = 1 << INDEX_W;

    logic             tag0_wren;
    logic             tag1_wren;
    logic             any_we;
    logic [DEPTH-1:0] valid0_q;                      // per set valid, way 0
    logic [DEPTH-1:0] valid1_q;
    logic [DEPTH-1:0] lru_q;                         // 1 means way 1 is victim
    logic             valid0_rd;
    logic             valid1_rd;
    logic             lru_rd;
    tag_t             tag0_rd;
    tag_t             tag1_rd;
    thread_t          thread0_rd;
    thread_t          thread1_rd;
    logic             dirty0_rd;
    logic             dirty1_rd;

    assign tag0_wren = way0_we & tag_we;
    assign tag1_wren = way1_we & tag_we;
    assign any_we    = way0_we | way1_we;

    // valid set on fill, LRU points at the way not just written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid0_q <= '0;
            valid1_q <= '0;
            lru_q    <= '0;
        end else begin
            if (tag0_wren) valid0_q[index] <= 1'b1;
            if (tag1_wren) valid1_q[index] <= 1'b1;
            if (any_we)    lru_q[index]    <= way0_we;  // way0 written -> lru 1
        end
    end

    // flop read path registered to line up with SRAM q
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid0_rd <= 1'b0;
            valid1_rd <= 1'b0;
            lru_rd    <= 1'b0;
        end else if (read_en) begin
            valid0_rd <= valid0_q[index];
            valid1_rd <= valid1_q[index];
            lru_rd    <= lru_q[index];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) w_complete <= 1'b0;
        else         w_complete <= any_we;
    end

    tag_sram #(.WIDTH(TAG_W), .DEPTH(DEPTH)) u_tag0 (
        .clk(clk), .address(index), .wren(tag0_wren), .rden(read_en),
        .data(tag_wd), .q(tag0_rd)
    );
    tag_sram #(.WIDTH(TAG_W), .DEPTH(DEPTH)) u_tag1 (
        .clk(clk), .address(index), .wren(tag1_wren), .rden(read_en),
        .data(tag_wd), .q(tag1_rd)
    );
    tag_sram #(.WIDTH(THREAD_W), .DEPTH(DEPTH)) u_thread0 (
        .clk(clk), .address(index), .wren(tag0_wren), .rden(read_en),
        .data(thread_wd), .q(thread0_rd)
    );
    tag_sram #(.WIDTH(THREAD_W), .DEPTH(DEPTH)) u_thread1 (
        .clk(clk), .address(index), .wren(tag1_wren), .rden(read_en),
        .data(thread_wd), .q(thread1_rd)
    );
    // dirty written on any access to the way
    tag_sram #(.WIDTH(1), .DEPTH(DEPTH)) u_dirty0 (
        .clk(clk), .address(index), .wren(way0_we), .rden(read_en),
        .data(dirty_set), .q(dirty0_rd)
    );
    tag_sram #(.WIDTH(1), .DEPTH(DEPTH)) u_dirty1 (
        .clk(clk), .address(index), .wren(way1_we), .rden(read_en),
        .data(dirty_set), .q(dirty1_rd)
    );

    always_comb begin
        way0.valid  = valid0_rd;
        way0.dirty  = dirty0_rd;
        way0.thread = thread0_rd;
        way0.tag    = tag0_rd;
        way1.valid  = valid1_rd;
        way1.dirty  = dirty1_rd;
        way1.thread = thread1_rd;
        way1.tag    = tag1_rd;
    end

    assign lru = lru_rd;

endmodule

`default_nettype wire

//--- src/tag_lookup.sv
/* dcache tag compare, hit and victim selection
   response registered two cycles after the lookup strobe */
`timescale 1ns/1ps
`default_nettype none

module tag_lookup import dcache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       lookup,
    input  tag_t       req_tag,
    input  way_entry_t way0,
    input  way_entry_t way1,
    input  way_t       lru,
    output logic       resp_valid,
    output tag_resp_t  resp
);

    logic       lookup_d;                            // aligned with SRAM q
    tag_t       req_tag_d;
    logic       hit0;
    logic       hit1;
    way_entry_t victim;
    tag_resp_t  resp_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lookup_d <= 1'b0;
        end else begin
            lookup_d <= lookup;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            req_tag_d <= req_tag;
        end
    end

    always_comb begin
        hit0   = way0.valid && (way0.tag == req_tag_d);
        hit1   = way1.valid && (way1.tag == req_tag_d);
        victim = lru ? way1 : way0;

        resp_next.hit        = hit0 | hit1;
        resp_next.hit_way    = hit1 & ~hit0;         // way 0 wins a double hit
        resp_next.victim_way = lru;

        // an empty victim has nothing to write back
        resp_next.victim_dirty  = victim.valid & victim.dirty;
        resp_next.victim_tag    = victim.valid ? victim.tag : '0;
        resp_next.victim_thread = victim.valid ? victim.thread : '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= lookup_d;                  // one-cycle pulse, t+2
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_d) begin
            resp <= resp_next;
        end
    end

endmodule

`default_nettype wire

//--- src/dcache_tag.sv
/* dcache tag store top level
   strobe decode into dtag_ram, lookup response from tag_lookup */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag import dcache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        lookup,                      // read both ways
    input  logic        fill,                        // L2 refill of wr_way
    input  logic        store,                       // mark wr_way dirty
    input  way_t        wr_way,
    input  cache_addr_t addr,
    input  thread_t     thread_id,
    output logic        resp_valid,
    output tag_resp_t   resp,
    output logic        w_complete
);

    logic       wr_en;
    logic       way0_we;
    logic       way1_we;
    way_entry_t way0;
    way_entry_t way1;
    way_t       lru;

    // per-way write enables, like block0_we / block1_we
    assign wr_en   = fill | store;
    assign way0_we = wr_en & ~wr_way;
    assign way1_we = wr_en & wr_way;

    dtag_ram u_dtag_ram (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (addr.index),
        .way0_we    (way0_we),
        .way1_we    (way1_we),
        .tag_we     (fill),                          // fill owns tag/thread/valid
        .dirty_set  (store),                         // fill writes dirty 0
        .read_en    (lookup),
        .tag_wd     (addr.tag),
        .thread_wd  (thread_id),
        .way0       (way0),
        .way1       (way1),
        .lru        (lru),
        .w_complete (w_complete)
    );

    tag_lookup u_tag_lookup (
        .clk        (clk),
        .arst_n     (arst_n),
        .lookup     (lookup),
        .req_tag    (addr.tag),
        .way0       (way0),
        .way1       (way1),
        .lru        (lru),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

`default_nettype wire

//--- verification/dcache_tag_checker.sv
/* dcache tag protocol checker
   strobe exclusivity, response and write completion timing */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_checker (
    input logic clk,
    input logic arst_n,
    input logic lookup,
    input logic fill,
    input logic store,
    input logic resp_valid,
    input logic w_complete
);

    // caller may raise only one strobe per cycle
    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({lookup, fill, store}))
        else $error("more than one of lookup, fill and store high");

    // SRAM read plus response register
    a_resp_timing: assert property (@(posedge clk) disable iff (!arst_n)
        resp_valid == $past(lookup, 2))
        else $error("resp_valid does not follow lookup by two cycles");

    a_wc_timing: assert property (@(posedge clk) disable iff (!arst_n)
        w_complete == $past(fill || store))
        else $error("w_complete does not follow a write by one cycle");

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!resp_valid && !w_complete))
        else $error("resp_valid or w_complete high during reset");

endmodule

bind dcache_tag dcache_tag_checker u_checker (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup     (lookup),
    .fill       (fill),
    .store      (store),
    .resp_valid (resp_valid),
    .w_complete (w_complete)
);

`default_nettype wire

//--- verification/dcache_tag_tb.sv
/* dcache tag store testbench
   replays golden operations and checks responses and w_complete */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_tb import dcache_pkg::*; ();

    localparam string GOLDEN_FILE = "verification/dcache_tag_golden.txt";
    localparam int    MAX_OPS     = 64;
    localparam int    CLK_HALF    = 20;                  // 40 ns period
    localparam int    DRIVE_DLY   = 2;

    logic        clk;
    logic        arst_n;
    logic        lookup;
    logic        fill;
    logic        store;
    way_t        wr_way;
    cache_addr_t addr;
    thread_t     thread_id;
    logic        resp_valid;
    tag_resp_t   resp;
    logic        w_complete;

    logic [7:0]  op_kind   [MAX_OPS];                    // L, F or S
    way_t        op_way    [MAX_OPS];
    tag_t        op_tag    [MAX_OPS];
    index_t      op_index  [MAX_OPS];
    thread_t     op_thread [MAX_OPS];
    tag_resp_t   op_exp    [MAX_OPS];
    int          n_ops;

    tag_resp_t   exp_q    [$];                           // lookups in flight
    int          exp_op_q [$];
    logic        cur_write;
    int          cur_op;
    logic        wr_d;
    int          wr_op_d;
    int          n_tests     = 0;
    int          errors      = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 1000;

    dcache_tag dcache_tag_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .lookup     (lookup),
        .fill       (fill),
        .store      (store),
        .wr_way     (wr_way),
        .addr       (addr),
        .thread_id  (thread_id),
        .resp_valid (resp_valid),
        .resp       (resp),
        .w_complete (w_complete)
    );

    always #CLK_HALF clk = ~clk;

    task automatic load_golden(output logic ok);
        int          fd;
        int          code;
        logic [7:0]  op;
        logic [31:0] f_way, f_tag, f_idx, f_thr;
        logic [31:0] f_hit, f_hw, f_vw, f_vd, f_vt, f_vth;
        logic [8*200-1:0] rest;
        ok    = 1'b1;
        n_ops = 0;
        fd    = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", GOLDEN_FILE);
            ok = 1'b0;
        end else begin
            code = $fscanf(fd, " %c", op);
            while (code == 1 && ok) begin
                if (op == "#") begin
                    code = $fgets(rest, fd);             // skip comment line
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", f_way, f_tag, f_idx, f_thr);
                    if (code != 4 || n_ops >= MAX_OPS || !(op == "L" || op == "F" || op == "S")) begin
                        $display("golden operation %0d is malformed", n_ops + 1);
                        ok = 1'b0;
                    end else begin
                        op_kind[n_ops]   = op;
                        op_way[n_ops]    = f_way[0];
                        op_tag[n_ops]    = f_tag[TAG_W-1:0];
                        op_index[n_ops]  = f_idx[INDEX_W-1:0];
                        op_thread[n_ops] = f_thr[THREAD_W-1:0];
                        op_exp[n_ops]    = '0;
                        if (op == "L") begin
                            code = $fscanf(fd, "%h %h %h %h %h %h",
                                           f_hit, f_hw, f_vw, f_vd, f_vt, f_vth);
                            if (code != 6) begin
                                $display("golden lookup %0d lacks its response", n_ops + 1);
                                ok = 1'b0;
                            end
                            op_exp[n_ops].hit           = f_hit[0];
                            op_exp[n_ops].hit_way       = f_hw[0];
                            op_exp[n_ops].victim_way    = f_vw[0];
                            op_exp[n_ops].victim_dirty  = f_vd[0];
                            op_exp[n_ops].victim_tag    = f_vt[TAG_W-1:0];
                            op_exp[n_ops].victim_thread = f_vth[THREAD_W-1:0];
                        end
                        n_ops++;
                    end
                end
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_idle();
        lookup    = 1'b0;
        fill      = 1'b0;
        store     = 1'b0;
        cur_write = 1'b0;
        cur_op    = -1;
    endtask

    task automatic drive_op(input int i);
        drive_idle();
        wr_way      = op_way[i];
        addr.tag    = op_tag[i];
        addr.index  = op_index[i];
        addr.offset = '0;
        thread_id   = op_thread[i];
        cur_op      = i;
        case (op_kind[i])
            "L": begin
                lookup = 1'b1;
                exp_q.push_back(op_exp[i]);
                exp_op_q.push_back(i);
            end
            "F": fill = 1'b1;
            "S": store = 1'b1;
            default: lookup = 1'b0;
        endcase
        cur_write = fill | store;
    endtask

    task automatic check_resp(input tag_resp_t exp, input tag_resp_t got, input int op_num);
        n_tests++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: op %0d lookup response mismatch", $time, op_num);
            $display("    expected hit %0b way %0b victim %0b dirty %0b tag %h thread %0d",
                     exp.hit, exp.hit_way, exp.victim_way, exp.victim_dirty,
                     exp.victim_tag, exp.victim_thread);
            $display("    got      hit %0b way %0b victim %0b dirty %0b tag %h thread %0d",
                     got.hit, got.hit_way, got.victim_way, got.victim_dirty,
                     got.victim_tag, got.victim_thread);
        end else begin
            $display("op %0d lookup ok, hit %0b way %0b victim %0b dirty %0b",
                     op_num, got.hit, got.hit_way, got.victim_way, got.victim_dirty);
        end
    endtask

    task automatic check_wc(input logic exp, input logic got, input int op_num);
        if (exp) n_tests++;
        if (got !== exp) begin
            errors++;
            $display("FAIL @%0t: w_complete is %0b, expected %0b after op %0d",
                     $time, got, exp, op_num);
        end else if (exp) begin
            $display("op %0d write ok, w_complete seen", op_num);
        end
    endtask

    // sample mid-cycle, away from the edges
    always @(negedge clk) begin
        tag_resp_t exp_r;
        int        exp_op;
        if (!arst_n) begin
            wr_d    = 1'b0;
            wr_op_d = -1;
        end else begin
            check_wc(wr_d, w_complete, wr_op_d);
            if (resp_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response at %0t with no lookup outstanding", $time);
                end else begin
                    exp_r  = exp_q.pop_front();
                    exp_op = exp_op_q.pop_front();
                    check_resp(exp_r, resp, exp_op);
                end
            end
            wr_d    = cur_write;                         // expect w_complete next cycle
            wr_op_d = cur_op;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run stopped after %0d cycles, %0d lookups never answered",
                     cycle_cnt, exp_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic load_ok;
        clk       = 1'b0;
        arst_n    = 1'b1;
        wr_way    = 1'b0;
        addr      = '0;
        thread_id = '0;
        drive_idle();
        load_golden(load_ok);
        if (!load_ok) begin
            $display("golden file could not be read, no stimulus applied");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            cycle_limit = (n_ops + 20) * 4;
            $display("loaded %0d operations, cycle limit %0d", n_ops, cycle_limit);
            #1 arst_n = 1'b0;                            // clean falling edge
            repeat (2) @(posedge clk);
            #DRIVE_DLY arst_n = 1'b1;
            for (int i = 0; i < n_ops; i++) begin
                @(posedge clk);
                #DRIVE_DLY;
                drive_op(i);
            end
            @(posedge clk);
            #DRIVE_DLY;
            drive_idle();
            while (exp_q.size() != 0) @(posedge clk);
            repeat (2) @(posedge clk);                   // last w_complete check
            $display("summary: %0d checks, %0d errors", n_tests, errors);
            if (errors == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dcache_tag.f
src/dcache_pkg.sv
src/tag_sram.sv
src/dtag_ram.sv
src/tag_lookup.sv
src/dcache_tag.sv
verification/dcache_tag_checker.sv
verification/dcache_tag_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the dcache tag testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f dcache_tag.f --top-module dcache_tag_tb -o dcache_tag_sim

status=0
./obj_dir/dcache_tag_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended abnormally, exit status $status"
    exit 1
fi
echo "simulation passed"

//--- verification/dcache_tag_golden.txt
# op way tag index thread, lookups add: hit hit_way victim_way victim_dirty victim_tag victim_thread
# all fields hex; lookups ignore way and thread, stores ignore tag and thread
L 0 0AAAAA 05 0 0 0 0 0 000000 0
L 0 1FFFFF FF 0 0 0 0 0 000000 0
F 0 012345 10 1
L 0 012345 10 0 1 0 1 0 000000 0
L 0 054321 10 0 0 0 1 0 000000 0
F 0 0A0A0A 20 2
F 1 0B0B0B 20 3
L 0 0A0A0A 20 0 1 0 0 0 0A0A0A 2
L 0 0B0B0B 20 0 1 1 0 0 0A0A0A 2
F 0 0C0C0C 20 1
L 0 0B0B0B 20 0 1 1 1 0 0B0B0B 3
L 0 0A0A0A 20 0 0 0 1 0 0B0B0B 3
F 0 111111 30 1
F 1 122222 30 2
S 0 111111 30 0
L 0 111111 30 0 1 0 1 0 122222 2
F 1 133333 30 2
L 0 111111 30 0 1 0 0 1 111111 1
F 0 144444 30 3
F 1 155555 30 0
L 0 144444 30 0 1 0 0 0 144444 3
S 1 155555 30 0
L 0 155555 30 0 1 1 0 0 144444 3
S 0 144444 30 0
L 0 155555 30 0 1 1 1 1 155555 0
L 0 012345 10 0 1 0 1 0 000000 0
L 0 0B0B0B 20 0 1 1 1 0 0B0B0B 3
L 0 144444 30 0 1 0 1 1 155555 0
L 0 0AAAAA 05 0 0 0 0 0 000000 0
